// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	localparam word_t RESET_PC = 32'h0000_0000;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type funct field
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_write_t;

	typedef struct packed {
		logic  valid;
		logic  we;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	// rs feeds operand a, rt feeds operand b or store data; zero when unused
	typedef struct packed {
		word_t      pc;
		alu_op_t    alu_op;
		word_t      a;
		word_t      b;
		word_t      store_data;
		reg_addr_t  rs;
		reg_addr_t  rt;
		logic       is_load;
		logic       is_store;
		reg_write_t wr;
	} id_ex_t;

	typedef struct packed {
		word_t     result;
		word_t     store_data;
		logic      is_load;
		logic      is_store;
		reg_addr_t waddr;
		logic      we;
	} ex_mem_t;

	typedef reg_write_t mem_wb_t;

endpackage

`default_nettype wire

// File: regs.sv
`default_nettype none

module regs import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  reg_write_t wr,
	input  reg_addr_t  raddr1,
	input  reg_addr_t  raddr2,
	output word_t      rdata1,
	output word_t      rdata2
);

	// Register zero is not stored
	word_t gpr [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				gpr[i] <= '0;
			end
		end else if (wr.we && wr.waddr != '0) begin
			gpr[wr.waddr] <= wr.wdata;
		end
	end

	function automatic word_t read_port(input reg_addr_t raddr);
		if (raddr == '0)
			return '0;
		// Write-through so WB and ID can share a cycle
		if (wr.we && wr.waddr == raddr)
			return wr.wdata;
		return gpr[raddr];
	endfunction

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule

`default_nettype wire

// File: reg_pc.sv
`default_nettype none

module reg_pc import cpu_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  stall,
	input  logic  jump,
	input  word_t jump_to,
	output word_t inst_addr,
	input  word_t inst_rdata,
	output word_t id_pc,
	output word_t id_inst
);

	word_t pc;

	assign inst_addr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (!stall) begin
			// Fetch in this cycle is the delay slot, so redirect applies next
			if (jump)
				pc <= jump_to;
			else
				pc <= pc + 32'd4;
		end
	end

	// IF/ID latch, an all-zero word is sll r0,r0,0
	always_ff @(posedge clk) begin
		if (rst) begin
			id_pc   <= RESET_PC;
			id_inst <= '0;
		end else if (!stall) begin
			id_pc   <= pc;
			id_inst <= inst_rdata;
		end
	end

endmodule

`default_nettype wire

// File: cpu_id.sv
`default_nettype none

module cpu_id import cpu_pkg::*; (
	input  word_t     id_pc,
	input  word_t     id_inst,
	input  word_t     rdata1,
	input  word_t     rdata2,
	output reg_addr_t raddr1,
	output reg_addr_t raddr2,
	input  word_t     ex_fwd,
	input  word_t     wb_fwd,
	input  fwd_sel_t  fwd_a,
	input  fwd_sel_t  fwd_b,
	output logic      is_branch,
	output logic      jump,
	output word_t     jump_to,
	output id_ex_t    id_out
);

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs_f, rt_f, rd_f;
	word_t      imm_s, imm_z, delay_pc;

	reg_addr_t src_a, src_b, dest;
	logic      wen, use_imm, is_load, is_store, is_beq, is_bne, is_j;
	word_t     imm_val, a_val, b_val;
	alu_op_t   alu;

	assign opcode   = id_inst[31:26];
	assign rs_f     = id_inst[25:21];
	assign rt_f     = id_inst[20:16];
	assign rd_f     = id_inst[15:11];
	assign funct    = id_inst[5:0];
	assign imm_s    = {{16{id_inst[15]}}, id_inst[15:0]};
	assign imm_z    = {16'h0000, id_inst[15:0]};
	assign delay_pc = id_pc + 32'd4;

	always_comb begin
		src_a    = '0;
		src_b    = '0;
		dest     = '0;
		wen      = 1'b0;
		use_imm  = 1'b0;
		imm_val  = imm_s;
		alu      = ALU_ADD;
		is_load  = 1'b0;
		is_store = 1'b0;
		is_beq   = 1'b0;
		is_bne   = 1'b0;
		is_j     = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				src_a = rs_f;
				src_b = rt_f;
				dest  = rd_f;
				wen   = 1'b1;
				case (funct)
					FN_ADDU: alu = ALU_ADD;
					FN_SUBU: alu = ALU_SUB;
					FN_AND:  alu = ALU_AND;
					FN_OR:   alu = ALU_OR;
					FN_XOR:  alu = ALU_XOR;
					FN_SLT:  alu = ALU_SLT;
					FN_SLL: begin
						// Shifted value rides in operand a, shamt in b
						alu     = ALU_SLL;
						src_a   = rt_f;
						src_b   = '0;
						use_imm = 1'b1;
						imm_val = {27'h0, id_inst[10:6]};
					end
					default: begin
						src_a = '0;
						src_b = '0;
						wen   = 1'b0;
					end
				endcase
			end
			OP_ADDIU: begin
				src_a   = rs_f;
				dest    = rt_f;
				wen     = 1'b1;
				use_imm = 1'b1;
			end
			OP_ORI: begin
				src_a   = rs_f;
				dest    = rt_f;
				wen     = 1'b1;
				use_imm = 1'b1;
				imm_val = imm_z;
				alu     = ALU_OR;
			end
			OP_LUI: begin
				dest    = rt_f;
				wen     = 1'b1;
				use_imm = 1'b1;
				imm_val = imm_z;
				alu     = ALU_LUI;
			end
			OP_LW: begin
				src_a   = rs_f;
				dest    = rt_f;
				wen     = 1'b1;
				use_imm = 1'b1;
				is_load = 1'b1;
			end
			OP_SW: begin
				src_a    = rs_f;
				src_b    = rt_f;
				use_imm  = 1'b1;
				is_store = 1'b1;
			end
			OP_BEQ: begin
				src_a  = rs_f;
				src_b  = rt_f;
				is_beq = 1'b1;
			end
			OP_BNE: begin
				src_a  = rs_f;
				src_b  = rt_f;
				is_bne = 1'b1;
			end
			OP_J:    is_j = 1'b1;
			default: ;
		endcase
	end

	assign raddr1 = src_a;
	assign raddr2 = src_b;

	always_comb begin
		case (fwd_a)
			FWD_MEM: a_val = ex_fwd;
			FWD_WB:  a_val = wb_fwd;
			default: a_val = rdata1;
		endcase
		case (fwd_b)
			FWD_MEM: b_val = ex_fwd;
			FWD_WB:  b_val = wb_fwd;
			default: b_val = rdata2;
		endcase
	end

	// Branch resolution, targets are relative to the delay slot
	assign is_branch = is_beq | is_bne;
	assign jump = is_j | (is_beq && a_val == b_val) | (is_bne && a_val != b_val);

	always_comb begin
		if (is_j)
			jump_to = {delay_pc[31:28], id_inst[25:0], 2'b00};
		else
			jump_to = delay_pc + {imm_s[29:0], 2'b00};
	end

	always_comb begin
		id_out            = '0;
		id_out.pc         = id_pc;
		id_out.alu_op     = alu;
		id_out.a          = a_val;
		id_out.b          = use_imm ? imm_val : b_val;
		id_out.store_data = b_val;
		id_out.rs         = src_a;
		id_out.rt         = src_b;
		id_out.is_load    = is_load;
		id_out.is_store   = is_store;
		id_out.wr.we      = wen && dest != '0;
		id_out.wr.waddr   = dest;
	end

endmodule

`default_nettype wire

// File: cpu_ex.sv
`default_nettype none

module cpu_ex import cpu_pkg::*; (
	input  id_ex_t   ex_in,
	input  fwd_sel_t fwd_a,
	input  fwd_sel_t fwd_b,
	input  word_t    mem_fwd,
	input  word_t    wb_fwd,
	output ex_mem_t  ex_out
);

	word_t a, b, rt_val, result;

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t base);
		case (sel)
			FWD_MEM: return mem_fwd;
			FWD_WB:  return wb_fwd;
			default: return base;
		endcase
	endfunction

	always_comb begin
		a      = fwd_mux(fwd_a, ex_in.a);
		rt_val = fwd_mux(fwd_b, ex_in.store_data);
		// A store keeps its offset in b, rt only feeds the data
		b      = ex_in.is_store ? ex_in.b : fwd_mux(fwd_b, ex_in.b);
	end

	always_comb begin
		case (ex_in.alu_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {31'h0, $signed(a) < $signed(b)};
			ALU_SLL: result = a << b[4:0];
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	always_comb begin
		ex_out.result     = result;
		ex_out.store_data = rt_val;
		ex_out.is_load    = ex_in.is_load;
		ex_out.is_store   = ex_in.is_store;
		ex_out.waddr      = ex_in.wr.waddr;
		ex_out.we         = ex_in.wr.we;
	end

endmodule

`default_nettype wire

// File: cpu_mem.sv
`default_nettype none

module cpu_mem import cpu_pkg::*; (
	input  ex_mem_t  mem_in,
	output mem_req_t data_req,
	input  word_t    data_rdata,
	output mem_wb_t  wb_out
);

	// One strobe per access, memory answers in the same cycle
	always_comb begin
		data_req.valid = mem_in.is_load | mem_in.is_store;
		data_req.we    = mem_in.is_store;
		data_req.addr  = mem_in.result;
		data_req.wdata = mem_in.store_data;
	end

	always_comb begin
		wb_out.we    = mem_in.we;
		wb_out.waddr = mem_in.waddr;
		wb_out.wdata = mem_in.is_load ? data_rdata : mem_in.result;
	end

endmodule

`default_nettype wire

// File: ctrl.sv
`default_nettype none

module ctrl import cpu_pkg::*; (
	input  reg_addr_t id_rs,
	input  reg_addr_t id_rt,
	input  logic      id_is_branch,
	input  id_ex_t    ex_in,
	input  ex_mem_t   mem_in,
	input  mem_wb_t   wb,
	output logic      stall,
	output fwd_sel_t  fwd_id_a,
	output fwd_sel_t  fwd_id_b,
	output fwd_sel_t  fwd_ex_a,
	output fwd_sel_t  fwd_ex_b
);

	logic ex_hit;

	// Newest producer wins
	function automatic fwd_sel_t pick(input reg_addr_t src, input ex_mem_t m, input mem_wb_t w);
		if (src == '0)
			return FWD_NONE;
		if (m.we && m.waddr == src)
			return FWD_MEM;
		if (w.we && w.waddr == src)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	assign ex_hit = ex_in.wr.we && ex_in.wr.waddr != '0 &&
		(ex_in.wr.waddr == id_rs || ex_in.wr.waddr == id_rt);

	// Load data, or any value a branch compares, is not ready until MEM
	assign stall = ex_hit && (ex_in.is_load || id_is_branch);

	always_comb begin
		fwd_id_a = pick(id_rs, mem_in, wb);
		fwd_id_b = pick(id_rt, mem_in, wb);
		fwd_ex_a = pick(ex_in.rs, mem_in, wb);
		fwd_ex_b = pick(ex_in.rt, mem_in, wb);
	end

endmodule

`default_nettype wire

// File: pipe_reg.sv
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	// All-zero payload has every valid and we bit clear
	always_ff @(posedge clk) begin
		if (rst || bubble)
			q <= '0;
		else
			q <= d;
	end

endmodule

`default_nettype wire

// File: trivial_mips.sv
`default_nettype none

module trivial_mips import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	output word_t    inst_addr,
	input  word_t    inst_rdata,
	output mem_req_t data_req,
	input  word_t    data_rdata
);

	reg_addr_t raddr1, raddr2;
	word_t     rdata1, rdata2;
	word_t     id_pc, id_inst, jump_to;
	logic      jump, stall, id_is_branch;
	fwd_sel_t  fwd_id_a, fwd_id_b, fwd_ex_a, fwd_ex_b;
	id_ex_t    id_ex_d, id_ex_q;
	ex_mem_t   ex_mem_d, ex_mem_q;
	mem_wb_t   mem_wb_d, mem_wb_q;

	regs u_regs (
		.clk,
		.rst,
		.wr(mem_wb_q),
		.raddr1,
		.raddr2,
		.rdata1,
		.rdata2
	);

	reg_pc u_reg_pc (
		.clk,
		.rst,
		.stall,
		.jump,
		.jump_to,
		.inst_addr,
		.inst_rdata,
		.id_pc,
		.id_inst
	);

	// ID sees MEM results through the load/ALU select
	cpu_id u_cpu_id (
		.id_pc,
		.id_inst,
		.rdata1,
		.rdata2,
		.raddr1,
		.raddr2,
		.ex_fwd(mem_wb_d.wdata),
		.wb_fwd(mem_wb_q.wdata),
		.fwd_a(fwd_id_a),
		.fwd_b(fwd_id_b),
		.is_branch(id_is_branch),
		.jump,
		.jump_to,
		.id_out(id_ex_d)
	);

	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk,
		.rst,
		.bubble(stall),
		.d(id_ex_d),
		.q(id_ex_q)
	);

	cpu_ex u_cpu_ex (
		.ex_in(id_ex_q),
		.fwd_a(fwd_ex_a),
		.fwd_b(fwd_ex_b),
		.mem_fwd(mem_wb_d.wdata),
		.wb_fwd(mem_wb_q.wdata),
		.ex_out(ex_mem_d)
	);

	pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk,
		.rst,
		.bubble(1'b0),
		.d(ex_mem_d),
		.q(ex_mem_q)
	);

	cpu_mem u_cpu_mem (
		.mem_in(ex_mem_q),
		.data_req,
		.data_rdata,
		.wb_out(mem_wb_d)
	);

	pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk,
		.rst,
		.bubble(1'b0),
		.d(mem_wb_d),
		.q(mem_wb_q)
	);

	ctrl u_ctrl (
		.id_rs(raddr1),
		.id_rt(raddr2),
		.id_is_branch,
		.ex_in(id_ex_q),
		.mem_in(ex_mem_q),
		.wb(mem_wb_q),
		.stall,
		.fwd_id_a,
		.fwd_id_b,
		.fwd_ex_a,
		.fwd_ex_b
	);

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none

module tb_mem_model import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  word_t    inst_addr,
	output word_t    inst_rdata,
	input  mem_req_t data_req,
	output word_t    data_rdata
);

	word_t prog [256];
	word_t data [256];

	// Every store since reset, in order
	word_t log_addr [$];
	word_t log_data [$];

	initial begin
		for (int i = 0; i < 256; i++) begin
			prog[i] = '0;
			data[i] = '0;
		end
	end

	// Both memories answer in the same cycle and wrap at 1 KiB
	assign inst_rdata = prog[inst_addr[9:2]];
	// Read data only while a load is strobed, X otherwise
	assign data_rdata = (data_req.valid && !data_req.we) ? data[data_req.addr[9:2]] : 'x;

	always @(posedge clk) begin
		if (rst) begin
			log_addr.delete();
			log_data.delete();
		end else if (data_req.valid && data_req.we) begin
			data[data_req.addr[9:2]] = data_req.wdata;
			log_addr.push_back(data_req.addr);
			log_data.push_back(data_req.wdata);
		end
	end

endmodule

`default_nettype wire

// File: tb_trivial_mips.sv
`default_nettype none

module tb_trivial_mips import cpu_pkg::*; ();

	logic     clk;
	logic     rst;
	word_t    inst_addr;
	word_t    inst_rdata;
	word_t    data_rdata;
	mem_req_t data_req;

	word_t exp_addr [$];
	word_t exp_data [$];
	int    checked;
	int    prog_len;
	word_t lfsr;

	trivial_mips u_trivial_mips (
		.clk,
		.rst,
		.inst_addr,
		.inst_rdata,
		.data_req,
		.data_rdata
	);

	tb_mem_model u_mem (
		.clk,
		.rst,
		.inst_addr,
		.inst_rdata,
		.data_req,
		.data_rdata
	);

	always #10 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR time %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// Each logged store against the next expected one
	always @(negedge clk) begin
		while (checked < u_mem.log_addr.size()) begin
			if (checked >= exp_addr.size())
				fail_run("The DUT made more stores than the program contains");
			check_value("data_req.addr", u_mem.log_addr[checked], exp_addr[checked]);
			check_value("data_req.wdata", u_mem.log_data[checked], exp_data[checked]);
			checked++;
		end
	end

	function automatic word_t lfsr_next(input word_t s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic word_t rand_bits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic word_t fill_word(input int idx, input int seed);
		return (word_t'(idx) + 32'd1 + word_t'(seed) * 32'd37) * 32'h9e37_79b9;
	endfunction

	function automatic word_t r_type(input logic [5:0] fn, input reg_addr_t rd,
		input reg_addr_t rs, input reg_addr_t rt, input logic [4:0] sh);
		return {OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rt,
		input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_type(input int idx);
		word_t w;
		w = word_t'(idx);
		return {OP_J, w[25:0]};
	endfunction

	function automatic logic [5:0] funct_of(input logic [2:0] idx);
		case (idx)
			3'd0:    return FN_ADDU;
			3'd1:    return FN_SUBU;
			3'd2:    return FN_AND;
			3'd3:    return FN_OR;
			3'd4:    return FN_XOR;
			3'd5:    return FN_SLT;
			default: return FN_SLL;
		endcase
	endfunction

	// Architectural model with one delay slot, returns the store count
	function automatic int run_iss();
		word_t      gpr [32];
		word_t      dmem [256];
		word_t      pc, npc, nnpc, inst, a, b, addr, simm, tgt;
		logic [5:0] op, fn;
		reg_addr_t  rs, rt, rd;
		for (int i = 0; i < 32; i++)
			gpr[i] = '0;
		for (int i = 0; i < 256; i++)
			dmem[i] = u_mem.data[i];
		exp_addr.delete();
		exp_data.delete();
		pc = RESET_PC;
		npc = RESET_PC + 32'd4;
		for (int step = 0; step < 20000; step++) begin
			inst = u_mem.prog[pc[9:2]];
			op = inst[31:26];
			rs = inst[25:21];
			rt = inst[20:16];
			rd = inst[15:11];
			fn = inst[5:0];
			simm = {{16{inst[15]}}, inst[15:0]};
			a = gpr[rs];
			b = gpr[rt];
			nnpc = npc + 32'd4;
			case (op)
				OP_RTYPE: begin
					case (fn)
						FN_ADDU: gpr[rd] = a + b;
						FN_SUBU: gpr[rd] = a - b;
						FN_AND:  gpr[rd] = a & b;
						FN_OR:   gpr[rd] = a | b;
						FN_XOR:  gpr[rd] = a ^ b;
						FN_SLT:  gpr[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL:  gpr[rd] = b << inst[10:6];
						default: ;
					endcase
				end
				OP_ADDIU: gpr[rt] = a + simm;
				OP_ORI:   gpr[rt] = a | {16'h0000, inst[15:0]};
				OP_LUI:   gpr[rt] = {inst[15:0], 16'h0000};
				OP_LW: begin
					addr = a + simm;
					gpr[rt] = dmem[addr[9:2]];
				end
				OP_SW: begin
					addr = a + simm;
					dmem[addr[9:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				OP_BEQ: begin
					if (a == b)
						nnpc = npc + {simm[29:0], 2'b00};
				end
				OP_BNE: begin
					if (a != b)
						nnpc = npc + {simm[29:0], 2'b00};
				end
				OP_J: begin
					tgt = {npc[31:28], inst[25:0], 2'b00};
					// Jump to itself ends the program
					if (tgt == pc)
						return exp_addr.size();
					nnpc = tgt;
				end
				default: ;
			endcase
			gpr[0] = '0;
			pc = npc;
			npc = nnpc;
		end
		return -1;
	endfunction

	task automatic emit(input word_t w);
		u_mem.prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic store_word(input reg_addr_t rt, input logic [15:0] off);
		emit(i_type(OP_SW, rt, 5'd0, off));
	endtask

	task automatic begin_program(input int seed);
		@(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < 256; i++) begin
			u_mem.prog[i] = '0;
			u_mem.data[i] = fill_word(i, seed);
		end
		prog_len = 0;
	endtask

	task automatic finish_program(input string name);
		int        n;
		int        cycles;
		reg_addr_t ra;
		// Dump all registers so the final state is compared as well
		for (int r = 0; r < 32; r++) begin
			ra = r[4:0];
			store_word(ra, {9'h000, ra, 2'b00} + 16'h0300);
		end
		emit(j_type(prog_len));
		emit('0);
		n = run_iss();
		if (n < 0)
			fail_run($sformatf("%s: reference model never reached the final jump", name));
		repeat (4) @(negedge clk);
		checked = 0;
		rst = 1'b0;
		cycles = 0;
		while (checked < n && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (checked < n)
			fail_run($sformatf("%s: stores stopped arriving, %0d of %0d seen", name, checked, n));
		// Room for an unexpected extra store to show up
		repeat (8) @(posedge clk);
		$display("%s: %0d stores match", name, n);
	endtask

	task automatic alu_program();
		begin_program(1);
		emit(i_type(OP_LUI, 5'd1, 5'd0, 16'h1234));
		emit(i_type(OP_ORI, 5'd1, 5'd1, 16'h5678));
		store_word(5'd1, 16'h0000);
		emit(i_type(OP_ADDIU, 5'd2, 5'd0, 16'hfffd));
		store_word(5'd2, 16'h0004);
		emit(r_type(FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
		store_word(5'd3, 16'h0008);
		emit(r_type(FN_SUBU, 5'd4, 5'd2, 5'd1, 5'd0));
		store_word(5'd4, 16'h000c);
		emit(r_type(FN_AND, 5'd5, 5'd1, 5'd2, 5'd0));
		store_word(5'd5, 16'h0010);
		emit(r_type(FN_OR, 5'd6, 5'd1, 5'd2, 5'd0));
		store_word(5'd6, 16'h0014);
		emit(r_type(FN_XOR, 5'd7, 5'd1, 5'd2, 5'd0));
		store_word(5'd7, 16'h0018);
		emit(r_type(FN_SLT, 5'd8, 5'd2, 5'd1, 5'd0));
		store_word(5'd8, 16'h001c);
		emit(r_type(FN_SLT, 5'd9, 5'd1, 5'd2, 5'd0));
		store_word(5'd9, 16'h0020);
		emit(r_type(FN_SLL, 5'd10, 5'd0, 5'd1, 5'd4));
		store_word(5'd10, 16'h0024);
		// Zero extension against sign extension
		emit(i_type(OP_ORI, 5'd11, 5'd0, 16'h8001));
		store_word(5'd11, 16'h0028);
		emit(i_type(OP_ADDIU, 5'd12, 5'd0, 16'h8001));
		store_word(5'd12, 16'h002c);
		finish_program("alu");
	endtask

	task automatic forward_program();
		begin_program(2);
		emit(i_type(OP_ADDIU, 5'd1, 5'd0, 16'h0005));
		emit(i_type(OP_ADDIU, 5'd1, 5'd1, 16'h0007));
		emit(r_type(FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0));
		emit(r_type(FN_SUBU, 5'd3, 5'd2, 5'd1, 5'd0));
		// r1 is being written back while this reads it
		emit(r_type(FN_OR, 5'd4, 5'd1, 5'd0, 5'd0));
		store_word(5'd3, 16'h0000);
		store_word(5'd4, 16'h0004);
		emit(i_type(OP_ADDIU, 5'd0, 5'd0, 16'h0063));
		emit(r_type(FN_ADDU, 5'd5, 5'd0, 5'd0, 5'd0));
		store_word(5'd0, 16'h0008);
		store_word(5'd5, 16'h000c);
		emit(r_type(FN_SLL, 5'd6, 5'd0, 5'd3, 5'd2));
		emit(r_type(FN_XOR, 5'd7, 5'd6, 5'd3, 5'd0));
		store_word(5'd7, 16'h0010);
		finish_program("forwarding");
	endtask

	task automatic load_use_program();
		begin_program(3);
		emit(i_type(OP_LW, 5'd1, 5'd0, 16'h0010));
		emit(r_type(FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0));
		store_word(5'd2, 16'h0000);
		emit(i_type(OP_LW, 5'd3, 5'd0, 16'h0014));
		store_word(5'd3, 16'h0004);
		emit(i_type(OP_LW, 5'd4, 5'd0, 16'h0018));
		emit(i_type(OP_LW, 5'd5, 5'd0, 16'h001c));
		emit(r_type(FN_ADDU, 5'd6, 5'd4, 5'd5, 5'd0));
		store_word(5'd6, 16'h0020);
		emit(i_type(OP_LW, 5'd7, 5'd0, 16'h0020));
		emit(r_type(FN_SLT, 5'd8, 5'd7, 5'd0, 5'd0));
		store_word(5'd8, 16'h0024);
		finish_program("load-use");
	endtask

	task automatic branch_program();
		begin_program(4);
		emit(i_type(OP_ADDIU, 5'd1, 5'd0, 16'h0001));
		emit(i_type(OP_ADDIU, 5'd2, 5'd0, 16'h0001));
		emit(i_type(OP_BEQ, 5'd2, 5'd1, 16'h0002));
		emit(i_type(OP_ADDIU, 5'd3, 5'd0, 16'h0003));
		emit(i_type(OP_ADDIU, 5'd4, 5'd0, 16'h0004));
		emit(i_type(OP_BNE, 5'd2, 5'd1, 16'h0002));
		emit(i_type(OP_ADDIU, 5'd5, 5'd0, 16'h0005));
		emit(i_type(OP_ADDIU, 5'd6, 5'd0, 16'h0006));
		// Compare needs the ALU result just ahead
		emit(i_type(OP_ADDIU, 5'd7, 5'd0, 16'h0007));
		emit(i_type(OP_BNE, 5'd1, 5'd7, 16'h0002));
		store_word(5'd7, 16'h0040);
		emit(i_type(OP_ADDIU, 5'd9, 5'd0, 16'h0009));
		emit(i_type(OP_ADDIU, 5'd10, 5'd0, 16'h0002));
		emit(i_type(OP_BEQ, 5'd1, 5'd10, 16'h0002));
		emit(i_type(OP_ADDIU, 5'd11, 5'd0, 16'h000b));
		emit(i_type(OP_ADDIU, 5'd12, 5'd0, 16'h000c));
		emit(j_type(prog_len + 3));
		emit(i_type(OP_ADDIU, 5'd13, 5'd0, 16'h000d));
		emit(i_type(OP_ADDIU, 5'd14, 5'd0, 16'h000e));
		// Backward loop, three passes through the delay slot
		emit(i_type(OP_ADDIU, 5'd15, 5'd0, 16'h0003));
		emit(i_type(OP_ADDIU, 5'd15, 5'd15, 16'hffff));
		emit(i_type(OP_BNE, 5'd0, 5'd15, 16'hfffe));
		emit(i_type(OP_ADDIU, 5'd16, 5'd16, 16'h0001));
		emit(i_type(OP_LW, 5'd17, 5'd0, 16'h0020));
		emit(i_type(OP_BNE, 5'd0, 5'd17, 16'h0002));
		emit(i_type(OP_ADDIU, 5'd18, 5'd0, 16'h0012));
		emit(i_type(OP_ADDIU, 5'd19, 5'd0, 16'h0013));
		finish_program("branch");
	endtask

	task automatic random_program(input int num);
		word_t sel;
		word_t ra;
		word_t rb;
		word_t rc;
		word_t v;
		begin_program(num + 10);
		for (int k = 0; k < 40; k++) begin
			sel = rand_bits(3);
			ra = rand_bits(5);
			rb = rand_bits(5);
			case (sel[2:0])
				3'd0, 3'd1, 3'd2: begin
					rc = rand_bits(5);
					v = rand_bits(3);
					if (funct_of(v[2:0]) == FN_SLL) begin
						v = rand_bits(5);
						emit(r_type(FN_SLL, ra[4:0], 5'd0, rb[4:0], v[4:0]));
					end else begin
						emit(r_type(funct_of(v[2:0]), ra[4:0], rb[4:0], rc[4:0], 5'd0));
					end
				end
				3'd3: begin
					v = rand_bits(16);
					emit(i_type(OP_ADDIU, ra[4:0], rb[4:0], v[15:0]));
				end
				3'd4: begin
					v = rand_bits(16);
					emit(i_type(OP_ORI, ra[4:0], rb[4:0], v[15:0]));
				end
				3'd5: begin
					v = rand_bits(16);
					emit(i_type(OP_LUI, ra[4:0], 5'd0, v[15:0]));
				end
				3'd6: begin
					v = rand_bits(8);
					emit(i_type(OP_LW, ra[4:0], 5'd0, {6'h00, v[7:0], 2'b00}));
				end
				default: begin
					v = rand_bits(8);
					emit(i_type(OP_SW, ra[4:0], 5'd0, {6'h00, v[7:0], 2'b00}));
				end
			endcase
		end
		finish_program($sformatf("random %0d", num));
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		lfsr = 32'd54;
		checked = 0;
		prog_len = 0;
		alu_program();
		forward_program();
		load_use_program();
		branch_program();
		for (int k = 0; k < 20; k++)
			random_program(k);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
cpu_pkg.sv
regs.sv
reg_pc.sv
cpu_id.sv
cpu_ex.sv
cpu_mem.sv
ctrl.sv
pipe_reg.sv
trivial_mips.sv
tb_mem_model.sv
tb_trivial_mips.sv
